//--- src/cpuConfig.sv
package cpuConfig;

    // ------------------------------------------------------------
    // Machine word
    // ------------------------------------------------------------

    localparam int dataWidth = 32;                 // RV32

    typedef logic [dataWidth-1:0] Data;            // All CSR values

    // ------------------------------------------------------------
    // Implemented ISA extensions, reported through misa
    // ------------------------------------------------------------

    localparam bit rvExtA = 1'b0;                  // Atomics
    localparam bit rvExtC = 1'b1;                  // Compressed
    localparam bit rvExtM = 1'b1;                  // Multiply and divide
    localparam bit rvExtI = 1'b1;                  // Base integer
    localparam bit rvExtU = 1'b0;                  // No user mode

    // MXL field of misa, 1 selects 32 bit
    localparam logic [1:0] misaXlen = 2'b01;

endpackage

//--- src/csrDefs.sv
package csrDefs;

    // ------------------------------------------------------------
    // Access ops and run modes
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        csrOpNop   = 2'd0,
        csrOpWrite = 2'd1,
        csrOpSet   = 2'd2,
        csrOpClear = 2'd3
    } CsrOp;

    typedef enum logic [1:0] {
        runModeUser    = 2'd0,
        runModeMachine = 2'd3
    } RunMode;

    // Same 12 bits seen whole or split into fields
    typedef union packed {
        logic [11:0] raw;                          // Full address decode
        struct packed {
            logic [1:0] access;                    // Read only when 2'b11
            logic [1:0] privilege;                 // Lowest mode allowed
            logic [7:0] index;                     // Counter number in low bits
        } field;
    } CsrAddr;

    // ------------------------------------------------------------
    // CSR addresses
    // ------------------------------------------------------------

    localparam logic [11:0] csrMvendorid     = 12'hF11;
    localparam logic [11:0] csrMarchid       = 12'hF12;
    localparam logic [11:0] csrMimpid        = 12'hF13;
    localparam logic [11:0] csrMhartid       = 12'hF14;
    localparam logic [11:0] csrMstatus       = 12'h300;
    localparam logic [11:0] csrMisa          = 12'h301;
    localparam logic [11:0] csrMie           = 12'h304;
    localparam logic [11:0] csrMtvec         = 12'h305;
    localparam logic [11:0] csrMcountinhibit = 12'h320;
    localparam logic [11:0] csrMhpmevent3    = 12'h323;  // First of the event selects
    localparam logic [11:0] csrMscratch      = 12'h340;
    localparam logic [11:0] csrMepc          = 12'h341;
    localparam logic [11:0] csrMcause        = 12'h342;
    localparam logic [11:0] csrMip           = 12'h344;
    localparam logic [11:0] csrMcycle        = 12'hB00;
    localparam logic [11:0] csrMinstret      = 12'hB02;
    localparam logic [11:0] csrMhpmcounter3  = 12'hB03;  // First programmable counter
    localparam logic [11:0] csrMcycleh       = 12'hB80;
    localparam logic [11:0] csrMinstreth     = 12'hB82;
    localparam logic [11:0] csrMhpmcounter3h = 12'hB83;

    // ------------------------------------------------------------
    // Performance events
    // ------------------------------------------------------------

    typedef enum logic [3:0] {
        hpmNone       = 4'd0,
        hpmICacheHit  = 4'd1,
        hpmICacheMiss = 4'd2,
        hpmDCacheHit  = 4'd3,
        hpmDCacheMiss = 4'd4,
        hpmMemRead    = 4'd5,
        hpmMemWrite   = 4'd6
    } HpmEvent;

    localparam int numCounterSlots = 10;           // Counters 0 to 9

endpackage

//--- src/hpmCounters.sv
`timescale 1ns/1ns

module hpmCounters #(
    parameter int numEventCounters = 2             // Counters 3 upward
) (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_cntWrite,       // Load indexed counter
    input  logic                 i_inhibitWrite,   // Load inhibit mask
    input  logic                 i_eventWrite,     // Load indexed event select
    input  logic [3:0]           i_cntIndex,
    input  cpuConfig::Data       i_wdata,
    input  logic                 i_evInstRet,
    input  logic                 i_evICacheHit,
    input  logic                 i_evICacheMiss,
    input  logic                 i_evDCacheHit,
    input  logic                 i_evDCacheMiss,
    input  logic                 i_evMemRead,
    input  logic                 i_evMemWrite,
    output logic [32:0]          o_cntValue,
    output csrDefs::HpmEvent     o_eventSel,
    output logic [csrDefs::numCounterSlots-1:0] o_inhibit
);

    localparam int slots = csrDefs::numCounterSlots;

    // Bit 1 has no counter behind it and stays clear
    localparam logic [slots-1:0] inhibitMask = {{(slots-2){1'b1}}, 2'b01};

    logic [32:0]      cntValue [slots];            // Per slot counter value
    csrDefs::HpmEvent eventSel [slots];            // Per slot event select
    logic [slots-1:0] inhibit;
    logic [15:0]      evByCode;                    // Event level by event code

    // Codes 7 to 15 select nothing
    assign evByCode = {9'b0, i_evMemWrite, i_evMemRead, i_evDCacheMiss, i_evDCacheHit,
                       i_evICacheMiss, i_evICacheHit, 1'b0};

    // ------------------------------------------------------------
    // Inhibit mask
    // ------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset)
            inhibit <= inhibitMask;                // Everything stopped
        else if (i_inhibitWrite)
            inhibit <= i_wdata[slots-1:0] & inhibitMask;
    end

    // ------------------------------------------------------------
    // Counter slots
    // ------------------------------------------------------------

    for (genvar i = 0; i < slots; i++) begin : gSlot
        if (i == 0 || i == 2 || (i >= 3 && i < 3 + numEventCounters)) begin : gCounter
            logic [32:0]      count;
            csrDefs::HpmEvent evSel;
            logic             trigger;

            if (i >= 3) begin : gSel
                always_ff @(posedge i_clock) begin
                    if (i_reset)
                        evSel <= csrDefs::hpmNone;
                    else if (i_eventWrite && i_cntIndex == 4'(i))
                        evSel <= csrDefs::HpmEvent'(i_wdata[3:0]);
                end
            end else begin : gFixed
                assign evSel = csrDefs::hpmNone;   // Cycle and instret are fixed
            end

            assign trigger = (i == 0) ? 1'b1 :
                             (i == 2) ? i_evInstRet : evByCode[evSel];

            always_ff @(posedge i_clock) begin
                if (i_reset)
                    count <= '0;
                else if (i_cntWrite && i_cntIndex == 4'(i))
                    count <= {1'b0, i_wdata};      // Load beats counting
                else if (trigger && !inhibit[i])
                    count <= count + 33'd1;
            end

            assign cntValue[i] = count;
            assign eventSel[i] = evSel;
        end else begin : gUnused
            assign cntValue[i] = '0;
            assign eventSel[i] = csrDefs::hpmNone;
        end
    end

    // Read back of the indexed slot
    assign o_cntValue = (i_cntIndex < 4'(slots)) ? cntValue[i_cntIndex] : '0;
    assign o_eventSel = (i_cntIndex < 4'(slots)) ? eventSel[i_cntIndex] : csrDefs::hpmNone;
    assign o_inhibit  = inhibit;

endmodule

//--- src/csrUnit.sv
`timescale 1ns/1ns

module csrUnit #(
    parameter int numEventCounters = 2             // Counters 3 upward
) (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  csrDefs::CsrOp        i_op,             // Access op
    input  csrDefs::CsrAddr      i_csr,            // Register address
    input  cpuConfig::Data       i_data,           // Operand
    input  logic [32:0]          i_cntValue,       // Indexed counter
    input  csrDefs::HpmEvent     i_eventSel,       // Indexed event select
    input  logic [csrDefs::numCounterSlots-1:0] i_inhibit,
    output cpuConfig::Data       o_data,           // Read value
    output logic                 o_illegal,
    output logic                 o_cntWrite,
    output logic                 o_inhibitWrite,
    output logic                 o_eventWrite,
    output logic [3:0]           o_cntIndex,
    output cpuConfig::Data       o_wdata
);

    localparam cpuConfig::Data misaValue =
        (cpuConfig::Data'(cpuConfig::rvExtA)   <<  0) |
        (cpuConfig::Data'(cpuConfig::rvExtC)   <<  2) |
        (cpuConfig::Data'(cpuConfig::rvExtI)   <<  8) |
        (cpuConfig::Data'(cpuConfig::rvExtM)   << 12) |
        (cpuConfig::Data'(cpuConfig::rvExtU)   << 20) |
        (cpuConfig::Data'(cpuConfig::misaXlen) << 30);

    csrDefs::RunMode mode;                         // Fixed at machine for now

    cpuConfig::Data  mtvec;
    cpuConfig::Data  mscratch;
    cpuConfig::Data  mcause;
    logic            mstatusMie;
    logic            mstatusMprv;
    logic [2:0]      mieBits;                      // MEIE, MTIE, MSIE
    logic [2:0]      mipBits;                      // MEIP, MTIP, MSIP

    cpuConfig::Data  rdata;
    cpuConfig::Data  wdata;
    logic            knownCsr;
    logic            badPrivilege;
    logic            accessOk;                     // Legal and not a nop
    logic            isCounterLo;
    logic            isCounterHi;
    logic            isEvent;

    // ------------------------------------------------------------
    // Address decode and privilege check
    // ------------------------------------------------------------

    assign isCounterLo = i_csr.raw == csrDefs::csrMcycle ||
                         i_csr.raw == csrDefs::csrMinstret ||
                         (i_csr.raw >= csrDefs::csrMhpmcounter3 &&
                          i_csr.raw < csrDefs::csrMhpmcounter3 + 12'(numEventCounters));
    assign isCounterHi = i_csr.raw == csrDefs::csrMcycleh ||
                         i_csr.raw == csrDefs::csrMinstreth ||
                         (i_csr.raw >= csrDefs::csrMhpmcounter3h &&
                          i_csr.raw < csrDefs::csrMhpmcounter3h + 12'(numEventCounters));
    assign isEvent     = i_csr.raw >= csrDefs::csrMhpmevent3 &&
                         i_csr.raw < csrDefs::csrMhpmevent3 + 12'(numEventCounters);

    assign badPrivilege = i_csr.field.privilege != mode;

    // ------------------------------------------------------------
    // Read multiplexer
    // ------------------------------------------------------------

    always_comb begin
        rdata    = '0;
        knownCsr = 1'b1;
        case (i_csr.raw)
            csrDefs::csrMvendorid,
            csrDefs::csrMarchid,
            csrDefs::csrMimpid,
            csrDefs::csrMhartid,
            csrDefs::csrMepc:          rdata = '0;  // Hardwired zero
            csrDefs::csrMisa:          rdata = misaValue;
            csrDefs::csrMstatus:       rdata = cpuConfig::Data'({mstatusMprv, 13'b0,
                                                                 mstatusMie, 3'b0});
            csrDefs::csrMie:           rdata = cpuConfig::Data'({mieBits[2], 3'b0, mieBits[1],
                                                                 3'b0, mieBits[0], 3'b0});
            csrDefs::csrMip:           rdata = cpuConfig::Data'({mipBits[2], 3'b0, mipBits[1],
                                                                 3'b0, mipBits[0], 3'b0});
            csrDefs::csrMtvec:         rdata = mtvec;
            csrDefs::csrMscratch:      rdata = mscratch;
            csrDefs::csrMcause:        rdata = mcause;
            csrDefs::csrMcountinhibit: rdata = cpuConfig::Data'(i_inhibit);
            default: begin
                if (isCounterLo)
                    rdata = i_cntValue[31:0];
                else if (isCounterHi)
                    rdata = cpuConfig::Data'(i_cntValue[32]);   // Overflow bit only
                else if (isEvent)
                    rdata = cpuConfig::Data'(i_eventSel);
                else
                    knownCsr = 1'b0;
            end
        endcase
    end

    assign o_data    = (knownCsr && !badPrivilege) ? rdata : '0;
    assign o_illegal = (i_op != csrDefs::csrOpNop) && (!knownCsr || badPrivilege);

    // ------------------------------------------------------------
    // Write data and register update
    // ------------------------------------------------------------

    always_comb begin
        case (i_op)
            csrDefs::csrOpSet:   wdata = rdata | i_data;
            csrDefs::csrOpClear: wdata = rdata & ~i_data;
            default:             wdata = i_data;
        endcase
    end

    assign accessOk = (i_op != csrDefs::csrOpNop) && knownCsr && !badPrivilege;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            mode        <= csrDefs::runModeMachine;
            mtvec       <= '0;
            mscratch    <= '0;
            mcause      <= '0;
            mstatusMie  <= 1'b0;
            mstatusMprv <= 1'b0;
            mieBits     <= '0;
            mipBits     <= '0;
        end else if (accessOk) begin
            case (i_csr.raw)
                csrDefs::csrMstatus: begin
                    mstatusMie  <= wdata[3];
                    mstatusMprv <= wdata[17];
                end
                csrDefs::csrMie:      mieBits  <= {wdata[11], wdata[7], wdata[3]};
                csrDefs::csrMip:      mipBits  <= {wdata[11], wdata[7], wdata[3]};
                csrDefs::csrMtvec:    mtvec    <= wdata;
                csrDefs::csrMscratch: mscratch <= wdata;
                csrDefs::csrMcause:   mcause   <= wdata;
                default: ;                         // Read only or held in the bank
            endcase
        end
    end

    // Strobes to the counter bank, high counter halves take no writes
    assign o_cntWrite     = accessOk && isCounterLo;
    assign o_inhibitWrite = accessOk && i_csr.raw == csrDefs::csrMcountinhibit;
    assign o_eventWrite   = accessOk && isEvent;
    assign o_cntIndex     = i_csr.field.index[3:0];
    assign o_wdata        = wdata;

endmodule

//--- src/csrSubsystem.sv
`timescale 1ns/1ns

module csrSubsystem #(
    parameter int numEventCounters = 2
) (
    input  logic             i_clock,
    input  logic             i_reset,
    input  csrDefs::CsrOp    i_op,
    input  csrDefs::CsrAddr  i_csr,
    input  cpuConfig::Data   i_data,
    input  logic             i_evInstRet,
    input  logic             i_evICacheHit,
    input  logic             i_evICacheMiss,
    input  logic             i_evDCacheHit,
    input  logic             i_evDCacheMiss,
    input  logic             i_evMemRead,
    input  logic             i_evMemWrite,
    output cpuConfig::Data   o_data,
    output logic             o_illegal
);

    logic                                cntWrite;
    logic                                inhibitWrite;
    logic                                eventWrite;
    logic [3:0]                          cntIndex;     // Shared read and write index
    cpuConfig::Data                      wdata;
    logic [32:0]                         cntValue;
    csrDefs::HpmEvent                    eventSel;
    logic [csrDefs::numCounterSlots-1:0] inhibit;

    csrUnit #(
        .numEventCounters(numEventCounters)
    ) csrFile (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_op          (i_op),
        .i_csr         (i_csr),
        .i_data        (i_data),
        .i_cntValue    (cntValue),
        .i_eventSel    (eventSel),
        .i_inhibit     (inhibit),
        .o_data        (o_data),
        .o_illegal     (o_illegal),
        .o_cntWrite    (cntWrite),
        .o_inhibitWrite(inhibitWrite),
        .o_eventWrite  (eventWrite),
        .o_cntIndex    (cntIndex),
        .o_wdata       (wdata)
    );

    hpmCounters #(
        .numEventCounters(numEventCounters)
    ) counterBank (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_cntWrite    (cntWrite),
        .i_inhibitWrite(inhibitWrite),
        .i_eventWrite  (eventWrite),
        .i_cntIndex    (cntIndex),
        .i_wdata       (wdata),
        .i_evInstRet   (i_evInstRet),
        .i_evICacheHit (i_evICacheHit),
        .i_evICacheMiss(i_evICacheMiss),
        .i_evDCacheHit (i_evDCacheHit),
        .i_evDCacheMiss(i_evDCacheMiss),
        .i_evMemRead   (i_evMemRead),
        .i_evMemWrite  (i_evMemWrite),
        .o_cntValue    (cntValue),
        .o_eventSel    (eventSel),
        .o_inhibit     (inhibit)
    );

endmodule

//--- verif/csrUnit_chk.sv
`timescale 1ns/1ns

module csrUnit_chk (
    input logic       i_clock,
    input logic       i_reset,
    input logic [1:0] i_op,
    input logic       i_illegal,
    input logic       i_cntWrite,
    input logic       i_inhibitWrite,
    input logic       i_eventWrite
);

    noIllegalOnNop: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_op == csrDefs::csrOpNop) |-> !i_illegal)
        else $error("o_illegal is high during a nop access");

    // Strobes only go out for legal accesses
    strobeIsLegal: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_cntWrite || i_inhibitWrite || i_eventWrite) |-> !i_illegal)
        else $error("counter bank strobe is high together with o_illegal");

    quietAfterReset: assert property (@(posedge i_clock)
        $fell(i_reset) |-> !i_illegal)
        else $error("o_illegal is high in the first cycle after reset");

endmodule

bind csrUnit csrUnit_chk unitChk (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_op          (i_op),
    .i_illegal     (o_illegal),
    .i_cntWrite    (o_cntWrite),
    .i_inhibitWrite(o_inhibitWrite),
    .i_eventWrite  (o_eventWrite)
);

//--- verif/csrMonitor.sv
`timescale 1ns/1ns

module csrMonitor (
    input  logic           i_clock,
    input  logic           i_check,        // Row under test is valid
    input  int             i_row,
    input  cpuConfig::Data i_data,
    input  logic           i_illegal,
    input  cpuConfig::Data i_expData,
    input  logic           i_expIllegal,
    output int             o_dataErrors,
    output int             o_illegalErrors
);

    int dataErrors = 0;
    int illegalErrors = 0;

    // ------------------------------------------------------------
    // Compare at the rising edge, inputs settled since the falling edge
    // ------------------------------------------------------------

    always @(posedge i_clock) begin
        if (i_check) begin
            if (i_data !== i_expData) begin
                $display("[FAIL] row %0d o_data got %h expected %h",
                         i_row, i_data, i_expData);
                dataErrors <= dataErrors + 1;
            end
            if (i_illegal !== i_expIllegal) begin
                $display("[FAIL] row %0d o_illegal got %h expected %h",
                         i_row, i_illegal, i_expIllegal);
                illegalErrors <= illegalErrors + 1;
            end
        end
    end

    assign o_dataErrors    = dataErrors;
    assign o_illegalErrors = illegalErrors;

endmodule

//--- verif/tbCsr.sv
`timescale 1ns/1ns

module tbCsr;

    localparam int numEventCounters = 2;           // Counters 3 and 4

    logic            clock;
    logic            reset;
    csrDefs::CsrOp   op;
    csrDefs::CsrAddr csr;
    cpuConfig::Data  data;
    logic [6:0]      ev;                           // Instret up to memory write
    cpuConfig::Data  dutData;
    logic            dutIllegal;
    cpuConfig::Data  expData;
    logic            expIllegal;
    logic            checkOn;
    int              rowNow;
    int              dataErrors;
    int              illegalErrors;
    int              cycles;
    int              cycleLimit;
    integer          seed;

    // ------------------------------------------------------------
    // Stimulus table, one row per cycle
    // ------------------------------------------------------------

    csrDefs::CsrOp   tOp[$];
    logic [11:0]     tAddr[$];
    cpuConfig::Data  tData[$];
    logic [6:0]      tEv[$];
    cpuConfig::Data  tExpData[$];
    logic            tExpIll[$];

    // Expected register state while the table is built
    cpuConfig::Data  mScratch;
    cpuConfig::Data  mCause;
    cpuConfig::Data  mTvec;
    cpuConfig::Data  mStatus;
    cpuConfig::Data  mIe;
    cpuConfig::Data  mIp;
    logic [9:0]      mInhibit;
    logic [32:0]     count [5];                    // Slot 1 unused
    logic [3:0]      evSel [5];

    csrSubsystem #(
        .numEventCounters(numEventCounters)
    ) uut (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_op          (op),
        .i_csr         (csr),
        .i_data        (data),
        .i_evInstRet   (ev[0]),
        .i_evICacheHit (ev[1]),
        .i_evICacheMiss(ev[2]),
        .i_evDCacheHit (ev[3]),
        .i_evDCacheMiss(ev[4]),
        .i_evMemRead   (ev[5]),
        .i_evMemWrite  (ev[6]),
        .o_data        (dutData),
        .o_illegal     (dutIllegal)
    );

    csrMonitor monitor (
        .i_clock        (clock),
        .i_check        (checkOn),
        .i_row          (rowNow),
        .i_data         (dutData),
        .i_illegal      (dutIllegal),
        .i_expData      (expData),
        .i_expIllegal   (expIllegal),
        .o_dataErrors   (dataErrors),
        .o_illegalErrors(illegalErrors)
    );

    always #4 clock = ~clock;                      // 8 ns period

    // ------------------------------------------------------------
    // Expected values from the register rules
    // ------------------------------------------------------------

    function automatic cpuConfig::Data expectedMisa();
        cpuConfig::Data value;
        value     = 32'h4000_0000;                 // MXL 1 for RV32
        value[0]  = cpuConfig::rvExtA;
        value[2]  = cpuConfig::rvExtC;
        value[8]  = cpuConfig::rvExtI;
        value[12] = cpuConfig::rvExtM;
        value[20] = cpuConfig::rvExtU;
        return value;
    endfunction

    function automatic cpuConfig::Data modelRead(input logic [11:0] addr, output logic known);
        cpuConfig::Data value;
        value = '0;
        known = 1'b1;
        case (addr)
            csrDefs::csrMvendorid,
            csrDefs::csrMarchid,
            csrDefs::csrMimpid,
            csrDefs::csrMhartid,
            csrDefs::csrMepc:          value = '0;
            csrDefs::csrMisa:          value = expectedMisa();
            csrDefs::csrMstatus:       value = mStatus;
            csrDefs::csrMie:           value = mIe;
            csrDefs::csrMip:           value = mIp;
            csrDefs::csrMtvec:         value = mTvec;
            csrDefs::csrMscratch:      value = mScratch;
            csrDefs::csrMcause:        value = mCause;
            csrDefs::csrMcountinhibit: value = {22'b0, mInhibit};
            csrDefs::csrMhpmevent3,
            csrDefs::csrMhpmevent3 + 12'd1: value = {28'b0, evSel[addr[2:0]]};
            csrDefs::csrMcycle,
            csrDefs::csrMinstret,
            csrDefs::csrMhpmcounter3,
            csrDefs::csrMhpmcounter3 + 12'd1: value = count[addr[2:0]][31:0];
            csrDefs::csrMcycleh,
            csrDefs::csrMinstreth,
            csrDefs::csrMhpmcounter3h,
            csrDefs::csrMhpmcounter3h + 12'd1: value = {31'b0, count[addr[2:0]][32]};
            default:                   known = 1'b0;
        endcase
        return value;
    endfunction

    function automatic logic eventLevel(input logic [3:0] code, input logic [6:0] events);
        if (code >= 4'd1 && code <= 4'd6)
            return events[code[2:0]];              // Codes line up with event bits
        return 1'b0;
    endfunction

    function automatic logic [6:0] randomEvents();
        integer r;
        r = $random(seed);
        return r[6:0];
    endfunction

    task automatic resetModel();
        mScratch = '0;
        mCause   = '0;
        mTvec    = '0;
        mStatus  = '0;
        mIe      = '0;
        mIp      = '0;
        mInhibit = 10'h3FD;                        // All ones except the missing bit 1
        for (int i = 0; i < 5; i++) begin
            count[i] = '0;
            evSel[i] = '0;
        end
    endtask

    // Adds a row, then moves the expected state past the next rising edge
    task automatic addRow(input csrDefs::CsrOp rowOp, input logic [11:0] addr,
                          input cpuConfig::Data value, input logic [6:0] events);
        cpuConfig::Data readValue;
        cpuConfig::Data writeValue;
        logic           known;
        logic           legal;
        readValue = modelRead(addr, known);
        legal     = known && addr[9:8] == 2'b11;   // Machine mode only
        tOp.push_back(rowOp);
        tAddr.push_back(addr);
        tData.push_back(value);
        tEv.push_back(events);
        tExpData.push_back(legal ? readValue : '0);
        tExpIll.push_back((rowOp != csrDefs::csrOpNop) && !legal);

        case (rowOp)
            csrDefs::csrOpSet:   writeValue = readValue | value;
            csrDefs::csrOpClear: writeValue = readValue & ~value;
            default:             writeValue = value;
        endcase

        // Counting sees the mask and selects from before the edge
        if (!mInhibit[0])
            count[0] = count[0] + 33'd1;
        if (events[0] && !mInhibit[2])
            count[2] = count[2] + 33'd1;
        if (eventLevel(evSel[3], events) && !mInhibit[3])
            count[3] = count[3] + 33'd1;
        if (eventLevel(evSel[4], events) && !mInhibit[4])
            count[4] = count[4] + 33'd1;

        if (rowOp != csrDefs::csrOpNop && legal) begin
            case (addr)
                csrDefs::csrMstatus:       mStatus  = writeValue & 32'h0002_0008;
                csrDefs::csrMie:           mIe      = writeValue & 32'h0000_0888;
                csrDefs::csrMip:           mIp      = writeValue & 32'h0000_0888;
                csrDefs::csrMtvec:         mTvec    = writeValue;
                csrDefs::csrMscratch:      mScratch = writeValue;
                csrDefs::csrMcause:        mCause   = writeValue;
                csrDefs::csrMcountinhibit: mInhibit = writeValue[9:0] & 10'h3FD;
                csrDefs::csrMhpmevent3,
                csrDefs::csrMhpmevent3 + 12'd1: evSel[addr[2:0]] = writeValue[3:0];
                csrDefs::csrMcycle,
                csrDefs::csrMinstret,
                csrDefs::csrMhpmcounter3,
                csrDefs::csrMhpmcounter3 + 12'd1: count[addr[2:0]] = {1'b0, writeValue};
                default: ;                         // Read only
            endcase
        end
    endtask

    task automatic readRow(input logic [11:0] addr);
        addRow(csrDefs::csrOpNop, addr, '0, '0);
    endtask

    task automatic buildTable();
        // Reset values
        addRow(csrDefs::csrOpSet, csrDefs::csrMstatus, '0, '0);   // Legal access right after reset
        readRow(csrDefs::csrMtvec);
        readRow(csrDefs::csrMcycle);
        readRow(csrDefs::csrMcountinhibit);
        readRow(csrDefs::csrMisa);
        readRow(csrDefs::csrMvendorid);
        readRow(csrDefs::csrMarchid);
        readRow(csrDefs::csrMimpid);
        readRow(csrDefs::csrMhartid);
        readRow(csrDefs::csrMepc);

        // Write, set and clear
        addRow(csrDefs::csrOpWrite, csrDefs::csrMscratch, 32'hA5A5_5A5A, '0);
        addRow(csrDefs::csrOpSet,   csrDefs::csrMscratch, 32'h0F0F_0000, '0);
        addRow(csrDefs::csrOpClear, csrDefs::csrMscratch, 32'hA000_000A, '0);
        readRow(csrDefs::csrMscratch);
        addRow(csrDefs::csrOpWrite, csrDefs::csrMcause, 32'h8000_0007, '0);
        addRow(csrDefs::csrOpSet,   csrDefs::csrMcause, 32'h0000_0030, '0);
        addRow(csrDefs::csrOpClear, csrDefs::csrMcause, 32'h0000_0007, '0);
        readRow(csrDefs::csrMcause);
        addRow(csrDefs::csrOpWrite, csrDefs::csrMstatus, 32'hFFFF_FFFF, '0);
        addRow(csrDefs::csrOpClear, csrDefs::csrMstatus, 32'h0000_0008, '0);
        readRow(csrDefs::csrMstatus);
        addRow(csrDefs::csrOpWrite, csrDefs::csrMie, 32'hFFFF_FFFF, '0);
        addRow(csrDefs::csrOpSet,   csrDefs::csrMip, 32'h0000_0F0F, '0);
        readRow(csrDefs::csrMie);
        readRow(csrDefs::csrMip);
        addRow(csrDefs::csrOpWrite, csrDefs::csrMtvec, 32'h0000_1001, '0);
        readRow(csrDefs::csrMtvec);

        // Cycle counter runs while enabled, then freezes
        addRow(csrDefs::csrOpClear, csrDefs::csrMcountinhibit, 32'h1, '0);
        for (int k = 0; k < 6; k++)
            readRow(csrDefs::csrMcycle);
        addRow(csrDefs::csrOpSet, csrDefs::csrMcountinhibit, 32'h1, '0);
        for (int k = 0; k < 3; k++)
            readRow(csrDefs::csrMcycle);

        // Event counters on random event levels
        addRow(csrDefs::csrOpWrite, csrDefs::csrMhpmevent3,
               cpuConfig::Data'(csrDefs::hpmICacheHit), '0);
        addRow(csrDefs::csrOpWrite, csrDefs::csrMhpmevent3 + 12'd1,
               cpuConfig::Data'(csrDefs::hpmMemWrite), '0);
        addRow(csrDefs::csrOpClear, csrDefs::csrMcountinhibit, 32'h1C, '0);
        for (int k = 0; k < 8; k++) begin
            addRow(csrDefs::csrOpNop, csrDefs::csrMinstret, '0, randomEvents());
            addRow(csrDefs::csrOpNop, csrDefs::csrMhpmcounter3, '0, randomEvents());
            addRow(csrDefs::csrOpNop, csrDefs::csrMhpmcounter3 + 12'd1, '0, randomEvents());
        end
        addRow(csrDefs::csrOpSet, csrDefs::csrMcountinhibit, 32'h1C, randomEvents());
        addRow(csrDefs::csrOpNop, csrDefs::csrMinstret, '0, randomEvents());
        addRow(csrDefs::csrOpNop, csrDefs::csrMhpmcounter3, '0, randomEvents());
        addRow(csrDefs::csrOpNop, csrDefs::csrMhpmcounter3 + 12'd1, '0, randomEvents());
        readRow(csrDefs::csrMhpmevent3);
        readRow(csrDefs::csrMhpmevent3 + 12'd1);

        // Load near the top and carry into bit 32
        addRow(csrDefs::csrOpWrite, csrDefs::csrMhpmcounter3, 32'hFFFF_FFFF, '0);
        addRow(csrDefs::csrOpClear, csrDefs::csrMcountinhibit, 32'h8, '0);
        addRow(csrDefs::csrOpNop, csrDefs::csrMhpmcounter3, '0, 7'b000_0010);
        addRow(csrDefs::csrOpSet, csrDefs::csrMcountinhibit, 32'h8, '0);
        readRow(csrDefs::csrMhpmcounter3);
        readRow(csrDefs::csrMhpmcounter3h);

        // Illegal addresses leave state alone
        addRow(csrDefs::csrOpWrite, 12'h7C0, 32'h0000_1234, '0);
        readRow(12'h7C0);
        addRow(csrDefs::csrOpWrite, 12'hC00, 32'h0000_0055, '0);   // User cycle alias
        readRow(csrDefs::csrMcycle);
        addRow(csrDefs::csrOpWrite, 12'hC03, 32'h0000_0055, '0);
        readRow(csrDefs::csrMhpmcounter3);
        addRow(csrDefs::csrOpWrite, csrDefs::csrMhpmcounter3 + 12'd2, 32'h77, '0);
        addRow(csrDefs::csrOpSet,   csrDefs::csrMhpmcounter3 + 12'd2, 32'h1, '0);
        readRow(csrDefs::csrMhpmcounter3 + 12'd2);
        readRow(csrDefs::csrMhpmcounter3h);
    endtask

    // ------------------------------------------------------------
    // Run
    // ------------------------------------------------------------

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, the table did not finish", cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        op         = csrDefs::csrOpNop;
        csr.raw    = '0;
        data       = '0;
        ev         = '0;
        expData    = '0;
        expIllegal = 1'b0;
        checkOn    = 1'b0;
        rowNow     = 0;
        cycles     = 0;
        seed       = 35194;
        resetModel();
        buildTable();
        cycleLimit = tOp.size() + 20;

        repeat (2) @(posedge clock);
        for (int r = 0; r < tOp.size(); r++) begin
            @(negedge clock);
            reset      = 1'b0;
            op         = tOp[r];
            csr.raw    = tAddr[r];
            data       = tData[r];
            ev         = tEv[r];
            expData    = tExpData[r];
            expIllegal = tExpIll[r];
            rowNow     = r;
            checkOn    = 1'b1;
        end
        @(negedge clock);
        checkOn = 1'b0;
        op      = csrDefs::csrOpNop;
        ev      = '0;

        $display("Error count: o_data %0d, o_illegal %0d", dataErrors, illegalErrors);
        if (dataErrors + illegalErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
src/cpuConfig.sv
src/csrDefs.sv
src/hpmCounters.sv
src/csrUnit.sv
src/csrSubsystem.sv
verif/csrUnit_chk.sv
verif/csrMonitor.sv
verif/tbCsr.sv

//--- Makefile
TOP = tbCsr

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ns --top-module $(TOP) -f vlog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir
